// File: include/zclk_consts.svh
// fixed stall lengths and phase numbers for the cpu clock generator, included by rtl and testbench
`ifndef ZCLK_CONSTS_SVH
`define ZCLK_CONSTS_SVH

// extra 28 MHz cycles a dos rom entry or exit keeps zclk stopped
// (one 7 MHz tact)
`define ZCLK_DOS_STALL 4

// extra cycles an external i/o access stops zclk in 14 MHz mode
// one 3.5 MHz tact
`define ZCLK_IO_STALL 8

// stall counter width, must hold the longest load
`define ZCLK_STALL_W 4

// phase counter width, four phases per frame
`define ZCLK_PHASE_W 2

// phase at which a new speed may be committed (c3)
`define ZCLK_RFSH_PHASE 3

`endif

// File: hw/zclk_mode_pkg.sv
// cpu clock speed type shared by the config register, the clock generator and the testbench
package zclk_mode_pkg;

	// requested and active z80 speed
	// upper bit set selects 14 MHz
	// value 3 has no name and runs at 14 MHz as well
	typedef enum logic [1:0]
	{
		// 8 clk cycles per zclk
		MODE_35  = 2'b00,
		// 4 clk cycles per zclk
		MODE_70  = 2'b01,
		// 2 clk cycles per zclk
		MODE_140 = 2'b10
	} turbo_mode_e;

	// 2 bits match the width of the config write port
	// reset value of both pending and active modes is MODE_35

endpackage

// File: hw/zclk_wait_pkg.sv
// wait-state cause type, held as the stall state of the clock generator
package zclk_wait_pkg;

	// reason the stall counter is running
	// dos beats i/o when both fire together
	typedef enum logic [1:0]
	{
		// counter at its end value, no stall
		WAIT_NONE = 2'b00,
		// dos rom entry or exit
		WAIT_DOS  = 2'b01,
		// external port access in 14 MHz mode
		WAIT_IO   = 2'b10
	} wait_cause_e;

	// 2'b11 is never loaded
	// level stalls (cpu, ide) are not counted
	// so they have no cause of their own

endpackage

// File: hw/clock_phaser.sv
// four-phase strobe sequencer, gives c0/c2/c3 from the 28 MHz clock for the clock generator
`timescale 1ns/1ns

module clock_phaser
(
	input  logic clk,
	input  logic rst,

	output logic c0,
	output logic c2,
	output logic c3
);

`include "zclk_consts.svh"

	// next phase to be shown on the strobes
	logic [`ZCLK_PHASE_W-1:0] phase;

	// strobes are registered, so c0 comes out right after reset
	// c1 has no user and is not decoded
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			phase <= '0;
			c0 <= 1'b0;
			c2 <= 1'b0;
			c3 <= 1'b0;
		end
		else
		begin
			// wraps every four cycles
			phase <= phase + 1'b1;
			c0 <= (phase == `ZCLK_PHASE_W'(0));
			c2 <= (phase == `ZCLK_PHASE_W'(2));
			// refresh commit phase
			c3 <= (phase == `ZCLK_PHASE_W'(`ZCLK_RFSH_PHASE));
		end
	end

endmodule

// File: hw/turbo_cfg.sv
// turbo configuration register, takes the requested cpu speed and applies it at a refresh
`timescale 1ns/1ns

module turbo_cfg
(
	input  logic clk,
	input  logic rst,

	input  logic cfg_we,
	input  zclk_mode_pkg::turbo_mode_e cfg_turbo,

	input  logic rfsh_n,
	input  logic c3,

	output zclk_mode_pkg::turbo_mode_e turbo
);

	import zclk_mode_pkg::*;

	// written mode, waits here for a refresh
	turbo_mode_e pending;

	// rfsh_n sampled every cycle
	logic rfsh_r;
	// rfsh_r as seen at the previous c3
	logic rfsh_old;

	// refresh start seen at phase c3
	logic rfsh_start;

	assign rfsh_start = c3 && rfsh_old && !rfsh_r;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			pending <= MODE_35;
			turbo <= MODE_35;
			rfsh_r <= 1'b1;
			rfsh_old <= 1'b1;
		end
		else
		begin
			rfsh_r <= rfsh_n;

			if (cfg_we)
				pending <= cfg_turbo;

			// old value only moves at c3, so a short low is still caught
			if (c3)
				rfsh_old <= rfsh_r;

			// speed only changes at a refresh, never mid bus cycle
			if (rfsh_start)
				turbo <= pending;
		end
	end

endmodule

// File: hw/zclock.sv
// z80 clock generator, makes zclk_out and the zpos/zneg edge strobes with the wait-state stalls
`timescale 1ns/1ns

module zclock
(
	input  logic clk,
	input  logic rst,

	input  zclk_mode_pkg::turbo_mode_e turbo,

	// phase strobes
	input  logic c0,
	input  logic c2,

	// i/o cycle to an external port
	input  logic iorq_s,
	input  logic external_port,

	// stall levels
	input  logic cpu_stall,
	input  logic ide_stall,

	// dos rom switch pulses
	input  logic dos_on,
	input  logic vdos_off,

	output logic zclk_out,
	output logic zpos,
	output logic zneg
);

`include "zclk_consts.svh"

	import zclk_mode_pkg::*;
	import zclk_wait_pkg::*;

	localparam logic [`ZCLK_STALL_W-1:0] DOS_LOAD = `ZCLK_DOS_STALL;
	localparam logic [`ZCLK_STALL_W-1:0] IO_LOAD = `ZCLK_IO_STALL;

	// remaining stalled cycles after the trigger cycle
	logic [`ZCLK_STALL_W-1:0] stall_count;
	wait_cause_e wait_cause;

	logic mode_140;
	logic dos_stall;
	logic io_stall;
	logic stall_start;
	logic stall;

	logic clk14_src;
	logic c2_cnt;
	logic pre_zpos;
	logic pre_zneg;

	// unnamed value 3 counts as 14 MHz too
	assign mode_140 = turbo[1];

	// triggers
	assign dos_stall = dos_on || vdos_off;
	assign io_stall = iorq_s && external_port && mode_140;
	assign stall_start = dos_stall || io_stall;

	// trigger cycle stalls too, then the counter takes over
	assign stall = cpu_stall || ide_stall || stall_start || (wait_cause != WAIT_NONE);

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			stall_count <= '0;
			wait_cause <= WAIT_NONE;
		end
		else if (stall_start)
		begin
			// dos wins over i/o
			if (dos_stall)
			begin
				stall_count <= DOS_LOAD;
				wait_cause <= WAIT_DOS;
			end
			else
			begin
				stall_count <= IO_LOAD;
				wait_cause <= WAIT_IO;
			end
		end
		else if (wait_cause != WAIT_NONE)
		begin
			stall_count <= stall_count - 1'b1;
			// last stalled cycle, back to idle
			if (stall_count == `ZCLK_STALL_W'(1))
				wait_cause <= WAIT_NONE;
		end
	end

	// 14 MHz source, frozen while stalled so the pin holds
	always_ff @(posedge clk)
	begin
		if (rst)
			clk14_src <= 1'b0;
		else if (!stall)
			clk14_src <= ~clk14_src;
	end

	// alternates zpos/zneg on c2 for 3.5 MHz
	always_ff @(posedge clk)
	begin
		if (rst)
			c2_cnt <= 1'b0;
		else if (c2)
			c2_cnt <= ~c2_cnt;
	end

	// pre-strobe select per speed
	always_comb
	begin
		case (turbo)
			MODE_35:
			begin
				pre_zpos = c2_cnt && c2;
				pre_zneg = !c2_cnt && c2;
			end
			MODE_70:
			begin
				pre_zpos = c2;
				pre_zneg = c0;
			end
			default:
			begin
				pre_zpos = clk14_src;
				pre_zneg = !clk14_src;
			end
		endcase
	end

	// gated by pin level so each strobe really flips zclk
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			zpos <= 1'b0;
			zneg <= 1'b0;
		end
		else
		begin
			zpos <= !stall && pre_zpos && zclk_out;
			zneg <= !stall && pre_zneg && !zclk_out;
		end
	end

	// pin moves half a clk early, zpos pulls low, zneg pulls high
	always_ff @(negedge clk)
	begin
		if (rst)
			zclk_out <= 1'b0;
		else if (zpos)
			zclk_out <= 1'b0;
		else if (zneg)
			zclk_out <= 1'b1;
	end

endmodule

// File: hw/zclk_top.sv
// cpu clock generator top, ties the phaser, the turbo register and the z80 clock block together
`timescale 1ns/1ns

module zclk_top
(
	input  logic clk,
	input  logic rst,

	// speed write
	input  logic cfg_we,
	input  zclk_mode_pkg::turbo_mode_e cfg_turbo,

	// cpu refresh, active low
	input  logic rfsh_n,

	input  logic iorq_s,
	input  logic external_port,
	input  logic cpu_stall,
	input  logic ide_stall,
	input  logic dos_on,
	input  logic vdos_off,

	output logic zclk_out,
	output logic zpos,
	output logic zneg
);

	import zclk_mode_pkg::*;

	logic c0;
	logic c2;
	logic c3;

	// active speed after the refresh commit
	turbo_mode_e turbo;

	clock_phaser u_phaser
	(
		.clk (clk),
		.rst (rst),
		.c0  (c0),
		.c2  (c2),
		.c3  (c3)
	);

	turbo_cfg u_turbo_cfg
	(
		.clk       (clk),
		.rst       (rst),
		.cfg_we    (cfg_we),
		.cfg_turbo (cfg_turbo),
		.rfsh_n    (rfsh_n),
		.c3        (c3),
		.turbo     (turbo)
	);

	zclock u_zclock
	(
		.clk           (clk),
		.rst           (rst),
		.turbo         (turbo),
		.c0            (c0),
		.c2            (c2),
		.iorq_s        (iorq_s),
		.external_port (external_port),
		.cpu_stall     (cpu_stall),
		.ide_stall     (ide_stall),
		.dos_on        (dos_on),
		.vdos_off      (vdos_off),
		.zclk_out      (zclk_out),
		.zpos          (zpos),
		.zneg          (zneg)
	);

endmodule

// File: tb/zclk_tb.sv
// directed testbench for the cpu clock generator, compile with the file list, top is zclk_tb
`timescale 1ns/1ns

module zclk_tb;

`include "zclk_consts.svh"

	import zclk_mode_pkg::*;
	import zclk_wait_pkg::*;

	localparam int CLK_PERIOD = 4;
	localparam int RESET_CYCLES = 10;
	// cycle budget per test, a little above the real length
	localparam int SPEED_CYCLES = 300;
	localparam int SWITCH_CYCLES = 120;
	localparam int STALL_CYCLES = 120;
	localparam int WAIT_CYCLES = 200;
	localparam int TOTAL_CYCLES = RESET_CYCLES + SPEED_CYCLES + SWITCH_CYCLES
		+ STALL_CYCLES + WAIT_CYCLES;
	localparam int TIMEOUT_NS = TOTAL_CYCLES * CLK_PERIOD * 2;

	logic clk = 1'b0;
	logic rst;
	logic cfg_we;
	turbo_mode_e cfg_turbo;
	logic rfsh_n;
	logic iorq_s;
	logic external_port;
	logic cpu_stall;
	logic ide_stall;
	logic dos_on;
	logic vdos_off;
	logic zclk_out;
	logic zpos;
	logic zneg;

	logic [31:0] rnd_state;

	zclk_top DUT (.*);

	// 28 MHz master clock stand-in
	always #(CLK_PERIOD / 2) clk = ~clk;

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// zclk period in clk cycles, upper bit alone means 14 MHz
	function automatic int mode_period(input turbo_mode_e mode);
		if (mode[1])
			return 2;
		else if (mode == MODE_70)
			return 4;
		else
			return 8;
	endfunction

	task automatic draw_rand(input int lo, input int span, output int val);
		rnd_state = xorshift(rnd_state);
		val = lo + int'(rnd_state % span);
	endtask

	task automatic check_value(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp)
		begin
			$display("** Error at %0t ns: %s, got %0d, expected %0d", $time, what, got, exp);
			$display("Some tests failed");
			$fatal(1, "stopped at the first mismatch");
		end
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) @(posedge clk);
	endtask

	// write a speed, then one refresh so it gets committed
	task automatic set_mode(input turbo_mode_e mode);
		@(posedge clk);
		cfg_we <= 1'b1;
		cfg_turbo <= mode;
		@(posedge clk);
		cfg_we <= 1'b0;
		rfsh_n <= 1'b0;
		// low across at least one c3
		idle_cycles(8);
		rfsh_n <= 1'b1;
		// high again so the next refresh is seen as a new one
		idle_cycles(8);
	endtask

	// strobe counts over a window plus zpos spacing
	task automatic measure_period(input int window, input int period);
		int npos;
		int nneg;
		int last;
		npos = 0;
		nneg = 0;
		last = -1;
		for (int i = 0; i < window; i++)
		begin
			@(posedge clk);
			#1;
			if (zpos)
			begin
				if (last >= 0)
					check_value("zpos spacing", i - last, period);
				last = i;
				npos++;
			end
			if (zneg)
				nneg++;
		end
		check_value("zpos count", npos, window / period);
		check_value("zneg count", nneg, window / period);
	endtask

	task automatic test_reset();
		for (int i = 1; i <= RESET_CYCLES; i++)
		begin
			@(posedge clk);
			if (i == RESET_CYCLES)
				rst <= 1'b0;
			#1;
			check_value("zpos in reset", zpos, 0);
			check_value("zneg in reset", zneg, 0);
			// pin is reset on the first falling edge only
			if (i > 1)
				check_value("zclk_out in reset", zclk_out, 0);
		end
		@(posedge clk);
		#1;
		check_value("zpos after reset", zpos, 0);
		check_value("zneg after reset", zneg, 0);
		check_value("zclk_out after reset", zclk_out, 0);
	endtask

	task automatic speed_window(input turbo_mode_e mode);
		set_mode(mode);
		idle_cycles(16);
		measure_period(64, mode_period(mode));
	endtask

	task automatic test_speed_periods();
		speed_window(MODE_35);
		speed_window(MODE_70);
		speed_window(MODE_140);
	endtask

	task automatic test_speed_switch();
		set_mode(MODE_35);
		idle_cycles(16);
		cfg_we <= 1'b1;
		cfg_turbo <= MODE_140;
		@(posedge clk);
		cfg_we <= 1'b0;
		// pending only, no refresh yet
		measure_period(32, mode_period(MODE_35));
		@(posedge clk);
		rfsh_n <= 1'b0;
		// c3 commit, then one cycle to line up with the pin
		idle_cycles(7);
		measure_period(16, mode_period(MODE_140));
		@(posedge clk);
		rfsh_n <= 1'b1;
		idle_cycles(8);
	endtask

	// sel 0 holds cpu_stall, sel 1 holds ide_stall
	task automatic level_stall(input int sel);
		int gap;
		int len;
		int seen;
		logic held;
		draw_rand(2, 6, gap);
		draw_rand(4, 16, len);
		idle_cycles(gap);
		if (sel == 0)
			cpu_stall <= 1'b1;
		else
			ide_stall <= 1'b1;
		for (int i = 1; i <= len; i++)
		begin
			@(posedge clk);
			if (i == len)
			begin
				cpu_stall <= 1'b0;
				ide_stall <= 1'b0;
			end
			#1;
			// level after the last strobe before the stall
			if (i == 1)
				held = zclk_out;
			check_value("strobe during level stall", zpos | zneg, 0);
			check_value("zclk_out during level stall", zclk_out, held);
		end
		seen = 0;
		for (int i = 0; i < 16; i++)
		begin
			@(posedge clk);
			#1;
			seen += zpos + zneg;
		end
		check_value("strobes after level stall", seen > 0, 1);
	endtask

	task automatic test_level_stalls();
		level_stall(0);
		level_stall(1);
	endtask

	// src 0 dos_on, 1 vdos_off, 2 external i/o, 3 dos_on with i/o
	task automatic wait_pulse(input int src);
		wait_cause_e cause;
		int gap;
		int quiet;
		cause = (src == 2) ? WAIT_IO : WAIT_DOS;
		// pulse cycle plus the counted cycles
		quiet = (cause == WAIT_IO) ? `ZCLK_IO_STALL + 1 : `ZCLK_DOS_STALL + 1;
		draw_rand(2, 6, gap);
		idle_cycles(gap);
		dos_on <= (src == 0 || src == 3);
		vdos_off <= (src == 1);
		iorq_s <= (src >= 2);
		external_port <= (src >= 2);
		for (int i = 1; i <= quiet + 1; i++)
		begin
			@(posedge clk);
			if (i == 1)
			begin
				dos_on <= 1'b0;
				vdos_off <= 1'b0;
				iorq_s <= 1'b0;
				external_port <= 1'b0;
			end
			#1;
			if (i <= quiet)
				check_value("strobe inside wait", zpos | zneg, 0);
			else
				check_value("strobe after wait", zpos | zneg, 1);
		end
	endtask

	task automatic test_wait_states();
		set_mode(MODE_140);
		idle_cycles(16);
		for (int src = 0; src < 4; src++)
			wait_pulse(src);
		// i/o wait only applies at 14 MHz
		set_mode(MODE_70);
		idle_cycles(16);
		iorq_s <= 1'b1;
		external_port <= 1'b1;
		measure_period(32, mode_period(MODE_70));
		@(posedge clk);
		iorq_s <= 1'b0;
		external_port <= 1'b0;
	endtask

	initial
	begin
		rst = 1'b1;
		cfg_we = 1'b0;
		cfg_turbo = MODE_35;
		rfsh_n = 1'b1;
		iorq_s = 1'b0;
		external_port = 1'b0;
		cpu_stall = 1'b0;
		ide_stall = 1'b0;
		dos_on = 1'b0;
		vdos_off = 1'b0;
		rnd_state = 32'd35;
		test_reset();
		test_speed_periods();
		test_speed_switch();
		test_level_stalls();
		test_wait_states();
		$display("All tests passed");
		$finish;
	end

	// watchdog
	initial
	begin
		#(TIMEOUT_NS);
		$display("timeout: the tests did not finish within %0d ns", TIMEOUT_NS);
		$display("Some tests failed");
		$fatal(1, "watchdog expired");
	end

endmodule

// File: zclk_sys.f
+incdir+include
hw/zclk_mode_pkg.sv
hw/zclk_wait_pkg.sv
hw/clock_phaser.sv
hw/turbo_cfg.sv
hw/zclock.sv
hw/zclk_top.sv
tb/zclk_tb.sv
